/* hdl/rf_config.svh */
`ifndef RF_CONFIG_SVH
`define RF_CONFIG_SVH

// Bits moved per cycle on each serial channel
`define RF_W 1

// SRAM data width, 8, 16 or 32
`define RF_RAM_WIDTH 8

// Extra slots placed after the 32 general registers
`define RF_CSR_REGS 4

// Register length in bits
`define RF_XLEN 32

`endif

/* hdl/rf_pkg.sv */
`include "rf_config.svh"

package rf_pkg;

   localparam int RF_RAW = $clog2(32 + `RF_CSR_REGS);   // Register index width
   localparam int RF_L2W = $clog2(`RF_RAM_WIDTH);
   // Register index plus byte-within-register count
   localparam int RF_AW  = $clog2(`RF_XLEN) + RF_RAW - RF_L2W;

   typedef logic [RF_RAW-1:0]        rf_reg_t;
   typedef logic [RF_AW-1:0]         rf_addr_t;
   typedef logic [`RF_RAM_WIDTH-1:0] rf_ram_data_t;

   typedef enum logic [1:0] {
      RF_OP_NONE  = 2'd0,
      RF_OP_READ  = 2'd1,
      RF_OP_WRITE = 2'd2
   } rf_op_e;

   // Read pair command
   typedef struct packed {
      rf_op_e                          op;
      logic [`RF_XLEN-2*RF_RAW-3:0]    pad;
      rf_reg_t                         rreg1;
      rf_reg_t                         rreg0;
   } rf_rd_cmd_t;

   // Write pair command, enables sit just above the register numbers
   typedef struct packed {
      rf_op_e                          op;
      logic [`RF_XLEN-2*RF_RAW-5:0]    pad;
      logic                            wen1;
      logic                            wen0;
      rf_reg_t                         wreg1;
      rf_reg_t                         wreg0;
   } rf_wr_cmd_t;

   // Same word, op in the top bits picks the view
   typedef union packed {
      rf_rd_cmd_t rd;
      rf_wr_cmd_t wr;
   } rf_cmd_u;

endpackage

/* hdl/wb_pkg.sv */
package wb_pkg;

   // Word addresses on the slave port
   typedef enum logic [1:0] {
      WB_DATA0 = 2'd0,   // Operand 0 on write, result 0 on read
      WB_DATA1 = 2'd1,   // Operand 1 on write, result 1 on read
      WB_CMD   = 2'd2,   // Write starts an operation
      WB_ID    = 2'd3    // Read only
   } wb_addr_e;

   typedef logic [31:0] wb_word_t;

   // Reads back as "SRF1"
   localparam wb_word_t WB_ID_VALUE = 32'h5352_4631;

endpackage

/* hdl/rf_ram_if.sv */
`timescale 1ns/1ps
`include "rf_config.svh"

module rf_ram_if
   import rf_pkg::*;
(
   input  logic               i_clk,
   input  logic               i_rst,
   // Serial side
   input  logic               i_wreq,
   input  logic               i_rreq,
   output logic               o_ready,
   input  rf_reg_t            i_wreg0,
   input  rf_reg_t            i_wreg1,
   input  logic               i_wen0,
   input  logic               i_wen1,
   input  logic [`RF_W-1:0]   i_wdata0,
   input  logic [`RF_W-1:0]   i_wdata1,
   input  rf_reg_t            i_rreg0,
   input  rf_reg_t            i_rreg1,
   output logic [`RF_W-1:0]   o_rdata0,
   output logic [`RF_W-1:0]   o_rdata1,
   // SRAM side
   output rf_addr_t           o_waddr,
   output rf_ram_data_t       o_wdata,
   output logic               o_wen,
   output rf_addr_t           o_raddr,
   output logic               o_ren,
   input  rf_ram_data_t       i_rdata
);

   localparam int W     = `RF_W;
   localparam int WIDTH = `RF_RAM_WIDTH;
   localparam int RATIO = WIDTH / W;       // Serial cycles per SRAM word
   localparam int CMSB  = 4 - $clog2(W);   // Cycle counter MSB
   localparam int L2R   = $clog2(RATIO);

   logic [CMSB:0]      rcnt;       // Shared cycle counter
   logic [CMSB:0]      wcnt;       // Write view of the counter, trails by 4
   logic               rgnt;
   logic               rreq_r;
   logic               rgate;
   logic               rtrig0;
   logic               rtrig1;
   logic               wtrig0;
   logic               wtrig1;
   logic               wtrig0_r;
   logic               wen0_r;
   logic               wen1_r;
   logic [WIDTH-1:0]   wdata0_r;
   logic [WIDTH+W-1:0] wdata1_r;   // One extra slot since channel 1 lands a cycle later
   logic [WIDTH-1:0]   rdata0;
   logic [WIDTH-W-1:0] rdata1;
   rf_reg_t            wreg;
   rf_reg_t            rreg;

   // Writes are granted at once, reads after the first fetch is under way
   assign o_ready = rgnt | i_wreq;

   assign wcnt   = rcnt - 4;
   assign wtrig0 = rtrig1;
   assign wtrig1 = wtrig0_r;

   assign o_wdata = wtrig1 ? wdata1_r[WIDTH-1:0] : wdata0_r;
   assign wreg    = wtrig1 ? i_wreg1 : i_wreg0;
   assign o_wen   = (wtrig0 & wen0_r) | (wtrig1 & wen1_r);

   // Channel 0 fetched one cycle, channel 1 the next
   assign rtrig0 = (rcnt[L2R-1:0] == 1);
   assign rreg   = rtrig0 ? i_rreg1 : i_rreg0;
   assign o_ren  = rgate & (rcnt[L2R-1:1] == '0);

   assign o_rdata0 = rdata0[W-1:0];
   // First bit of channel 1 taken straight off the RAM
   assign o_rdata1 = rtrig1 ? i_rdata[W-1:0] : rdata1[W-1:0];

   generate
      if (WIDTH == 32) begin : gen_addr_word
         assign o_waddr = wreg;     // One word per register
         assign o_raddr = rreg;
      end else begin : gen_addr_part
         assign o_waddr = {wreg, wcnt[CMSB:L2R]};
         assign o_raddr = {rreg, rcnt[CMSB:L2R]};
      end
   endgenerate

   // Gather incoming bits, enables sampled every other cycle
   always_ff @(posedge i_clk) begin
      wtrig0_r <= wtrig0;
      if (wcnt[0]) begin
         wen0_r <= i_wen0;
         wen1_r <= i_wen1;
      end
      wdata0_r <= {i_wdata0, wdata0_r[WIDTH-1:W]};
      wdata1_r <= {i_wdata1, wdata1_r[WIDTH+W-1:W]};
   end

   // Prefetched words shifted out LSB first
   always_ff @(posedge i_clk) begin
      rtrig1 <= rtrig0;
      rdata0 <= {{W{1'b0}}, rdata0[WIDTH-1:W]};
      if (rtrig0) begin
         rdata0 <= i_rdata;
      end
      rdata1 <= {{W{1'b0}}, rdata1[WIDTH-W-1:W]};
      if (rtrig1) begin
         rdata1 <= i_rdata[WIDTH-1:W];
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rcnt   <= '0;
         rgate  <= 1'b0;
         rreq_r <= 1'b0;
         rgnt   <= 1'b0;
      end else begin
         rcnt <= rcnt + 1'b1;
         // Writes start at 2 to absorb the gather delay
         if (i_rreq | i_wreq) begin
            rcnt <= {{(CMSB-1){1'b0}}, i_wreq, 1'b0};
         end
         if ((&rcnt) | i_rreq) begin
            rgate <= i_rreq;   // Drops after the last fetch
         end
         rreq_r <= i_rreq;
         rgnt   <= rreq_r;
      end
   end

endmodule

/* hdl/rf_ram.sv */
`timescale 1ns/1ps

module rf_ram
   import rf_pkg::*;
(
   input  logic         i_clk,
   input  rf_addr_t     i_waddr,
   input  rf_ram_data_t i_wdata,
   input  logic         i_wen,
   input  rf_addr_t     i_raddr,
   input  logic         i_ren,
   output rf_ram_data_t o_rdata
);

   localparam int DEPTH = 1 << $bits(rf_addr_t);

   rf_ram_data_t mem [DEPTH];

   always_ff @(posedge i_clk) begin
      if (i_wen) begin
         mem[i_waddr] <= i_wdata;
      end
      // Same address read sees the old word
      if (i_ren) begin
         o_rdata <= mem[i_raddr];
      end
   end

endmodule

/* hdl/rf_serdes.sv */
`timescale 1ns/1ps
`include "rf_config.svh"

module rf_serdes (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic                 i_start,
   input  logic                 i_dir,     // 1 write, 0 read
   input  logic [`RF_XLEN-1:0]  i_op0,
   input  logic [`RF_XLEN-1:0]  i_op1,
   output logic                 o_wreq,
   output logic                 o_rreq,
   input  logic                 i_ready,
   output logic [`RF_W-1:0]     o_wdata0,
   output logic [`RF_W-1:0]     o_wdata1,
   input  logic [`RF_W-1:0]     i_rdata0,
   input  logic [`RF_W-1:0]     i_rdata1,
   output logic [`RF_XLEN-1:0]  o_res0,
   output logic [`RF_XLEN-1:0]  o_res1,
   output logic                 o_done
);

   localparam int W     = `RF_W;
   localparam int XLEN  = `RF_XLEN;
   localparam int NBEAT = XLEN / W;
   localparam int CW    = $clog2(NBEAT);

   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_WAIT = 2'd1;   // Request out, waiting for ready
   localparam logic [1:0] ST_RUN  = 2'd2;

   logic [1:0]      state;
   logic [CW-1:0]   cnt;
   // One register per channel, operand leaves at the bottom as results enter at the top
   logic [XLEN-1:0] sh0;
   logic [XLEN-1:0] sh1;

   assign o_wdata0 = sh0[W-1:0];
   assign o_wdata1 = sh1[W-1:0];
   assign o_res0   = sh0;
   assign o_res1   = sh1;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state  <= ST_IDLE;
         cnt    <= '0;
         o_wreq <= 1'b0;
         o_rreq <= 1'b0;
         o_done <= 1'b0;
      end else begin
         o_wreq <= 1'b0;
         o_rreq <= 1'b0;
         o_done <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (i_start) begin
                  o_wreq <= i_dir;
                  o_rreq <= ~i_dir;
                  state  <= ST_WAIT;
               end
            end
            ST_WAIT: begin
               if (i_ready) begin
                  cnt   <= '0;
                  state <= ST_RUN;
               end
            end
            ST_RUN: begin
               cnt <= cnt + 1'b1;
               if (cnt == CW'(NBEAT - 1)) begin
                  o_done <= 1'b1;
                  state  <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_start) begin
         sh0 <= i_op0;
         sh1 <= i_op1;
      end else if (state == ST_RUN) begin
         sh0 <= {i_rdata0, sh0[XLEN-1:W]};   // LSB first both ways
         sh1 <= {i_rdata1, sh1[XLEN-1:W]};
      end
   end

endmodule

/* hdl/rf_op_ctrl.sv */
`timescale 1ns/1ps
`include "rf_config.svh"

module rf_op_ctrl
   import rf_pkg::*, wb_pkg::*;
(
   input  logic                 i_clk,
   input  logic                 i_rst,
   // Wishbone classic slave
   input  logic                 i_wb_cyc,
   input  logic                 i_wb_stb,
   input  logic                 i_wb_we,
   input  logic [1:0]           i_wb_adr,
   input  wb_word_t             i_wb_dat,
   output wb_word_t             o_wb_dat,
   output logic                 o_wb_ack,
   // Serial engine
   output logic                 o_start,
   output logic                 o_dir,
   output logic [`RF_XLEN-1:0]  o_op0,
   output logic [`RF_XLEN-1:0]  o_op1,
   input  logic [`RF_XLEN-1:0]  i_res0,
   input  logic [`RF_XLEN-1:0]  i_res1,
   input  logic                 i_done,
   // Register selection, held for the whole operation
   output rf_reg_t              o_wreg0,
   output rf_reg_t              o_wreg1,
   output logic                 o_wen0,
   output logic                 o_wen1,
   output rf_reg_t              o_rreg0,
   output rf_reg_t              o_rreg1
);

   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_BUSY = 2'd1;   // Serial op running, ack withheld
   localparam logic [1:0] ST_RESP = 2'd2;   // Ack cycle

   logic [1:0]          state;
   rf_cmd_u             cmd;       // Last command written
   rf_cmd_u             new_cmd;
   logic [`RF_XLEN-1:0] res0;
   logic [`RF_XLEN-1:0] res1;
   logic                req;
   logic                cmd_wr;
   logic                cmd_run;
   logic                busy;

   assign new_cmd = i_wb_dat;
   assign busy    = (state == ST_BUSY);

   // Fresh access only, ack cycle excluded
   assign req     = i_wb_cyc & i_wb_stb & ~o_wb_ack & (state == ST_IDLE);
   assign cmd_wr  = req & i_wb_we & (i_wb_adr == WB_CMD);
   assign cmd_run = cmd_wr & ((new_cmd.rd.op == RF_OP_READ) | (new_cmd.rd.op == RF_OP_WRITE));

   assign o_dir = (cmd.wr.op == RF_OP_WRITE);

   always_comb begin
      o_wreg0 = '0;
      o_wreg1 = '0;
      o_wen0  = 1'b0;
      o_wen1  = 1'b0;
      o_rreg0 = '0;
      o_rreg1 = '0;
      case (cmd.rd.op)
         RF_OP_READ: begin
            o_rreg0 = cmd.rd.rreg0;
            o_rreg1 = cmd.rd.rreg1;
         end
         RF_OP_WRITE: begin
            o_wreg0 = cmd.wr.wreg0;
            o_wreg1 = cmd.wr.wreg1;
            o_wen0  = cmd.wr.wen0 & busy;   // No stray byte writes once done
            o_wen1  = cmd.wr.wen1 & busy;
         end
         default: ;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state    <= ST_IDLE;
         o_wb_ack <= 1'b0;
         o_start  <= 1'b0;
         cmd      <= '0;
      end else begin
         o_wb_ack <= 1'b0;
         o_start  <= 1'b0;
         if (cmd_wr) begin
            cmd <= new_cmd;
         end
         case (state)
            ST_IDLE: begin
               if (cmd_run) begin
                  o_start <= 1'b1;
                  state   <= ST_BUSY;
               end else if (req) begin
                  o_wb_ack <= 1'b1;   // Includes op NONE
               end
            end
            ST_BUSY: begin
               if (i_done) begin
                  o_wb_ack <= 1'b1;
                  state    <= ST_RESP;
               end
            end
            ST_RESP: state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Host writes to DATAx set both operand and readback, a read op replaces the readback
   always_ff @(posedge i_clk) begin
      if (req) begin
         case (i_wb_adr)
            WB_DATA0: begin
               if (i_wb_we) begin
                  o_op0 <= i_wb_dat;
                  res0  <= i_wb_dat;
               end
               o_wb_dat <= res0;
            end
            WB_DATA1: begin
               if (i_wb_we) begin
                  o_op1 <= i_wb_dat;
                  res1  <= i_wb_dat;
               end
               o_wb_dat <= res1;
            end
            WB_CMD:  o_wb_dat <= cmd;
            default: o_wb_dat <= WB_ID_VALUE;
         endcase
      end
      if (busy & i_done & (cmd.rd.op == RF_OP_READ)) begin
         res0 <= i_res0;
         res1 <= i_res1;
      end
   end

endmodule

/* hdl/serial_rf_top.sv */
`timescale 1ns/1ps
`include "rf_config.svh"

module serial_rf_top
   import rf_pkg::*, wb_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_rst,
   input  logic       i_wb_cyc,
   input  logic       i_wb_stb,
   input  logic       i_wb_we,
   input  logic [1:0] i_wb_adr,
   input  wb_word_t   i_wb_dat,
   output wb_word_t   o_wb_dat,
   output logic       o_wb_ack
);

   // Controller to serdes
   logic                start;
   logic                dir;
   logic                done;
   logic [`RF_XLEN-1:0] op0;
   logic [`RF_XLEN-1:0] op1;
   logic [`RF_XLEN-1:0] res0;
   logic [`RF_XLEN-1:0] res1;

   // Serial channels
   logic                wreq;
   logic                rreq;
   logic                ready;
   logic [`RF_W-1:0]    wdata0;
   logic [`RF_W-1:0]    wdata1;
   logic [`RF_W-1:0]    rdata0;
   logic [`RF_W-1:0]    rdata1;

   // Register selection
   rf_reg_t             wreg0;
   rf_reg_t             wreg1;
   rf_reg_t             rreg0;
   rf_reg_t             rreg1;
   logic                wen0;
   logic                wen1;

   // SRAM port pair
   rf_addr_t            waddr;
   rf_addr_t            raddr;
   rf_ram_data_t        ram_wdata;
   rf_ram_data_t        ram_rdata;
   logic                ram_wen;
   logic                ram_ren;

   rf_op_ctrl u_ctrl (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_wb_cyc (i_wb_cyc),
      .i_wb_stb (i_wb_stb),
      .i_wb_we  (i_wb_we),
      .i_wb_adr (i_wb_adr),
      .i_wb_dat (i_wb_dat),
      .o_wb_dat (o_wb_dat),
      .o_wb_ack (o_wb_ack),
      .o_start  (start),
      .o_dir    (dir),
      .o_op0    (op0),
      .o_op1    (op1),
      .i_res0   (res0),
      .i_res1   (res1),
      .i_done   (done),
      .o_wreg0  (wreg0),
      .o_wreg1  (wreg1),
      .o_wen0   (wen0),
      .o_wen1   (wen1),
      .o_rreg0  (rreg0),
      .o_rreg1  (rreg1)
   );

   rf_serdes u_serdes (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_start  (start),
      .i_dir    (dir),
      .i_op0    (op0),
      .i_op1    (op1),
      .o_wreq   (wreq),
      .o_rreq   (rreq),
      .i_ready  (ready),
      .o_wdata0 (wdata0),
      .o_wdata1 (wdata1),
      .i_rdata0 (rdata0),
      .i_rdata1 (rdata1),
      .o_res0   (res0),
      .o_res1   (res1),
      .o_done   (done)
   );

   rf_ram_if u_ram_if (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_wreq   (wreq),
      .i_rreq   (rreq),
      .o_ready  (ready),
      .i_wreg0  (wreg0),
      .i_wreg1  (wreg1),
      .i_wen0   (wen0),
      .i_wen1   (wen1),
      .i_wdata0 (wdata0),
      .i_wdata1 (wdata1),
      .i_rreg0  (rreg0),
      .i_rreg1  (rreg1),
      .o_rdata0 (rdata0),
      .o_rdata1 (rdata1),
      .o_waddr  (waddr),
      .o_wdata  (ram_wdata),
      .o_wen    (ram_wen),
      .o_raddr  (raddr),
      .o_ren    (ram_ren),
      .i_rdata  (ram_rdata)
   );

   rf_ram u_ram (
      .i_clk    (i_clk),
      .i_waddr  (waddr),
      .i_wdata  (ram_wdata),
      .i_wen    (ram_wen),
      .i_raddr  (raddr),
      .i_ren    (ram_ren),
      .o_rdata  (ram_rdata)
   );

endmodule

/* tb/tb_serial_rf.sv */
`timescale 1ns/1ps
`include "rf_config.svh"

module tb_serial_rf
   import rf_pkg::*, wb_pkg::*;
();

   localparam int N_OPS       = 120;                  // Serial operations over all tests
   localparam int WD_CYCLES   = N_OPS * 100 + 2000;   // Watchdog limit
   localparam int ACK_TIMEOUT = 200;                  // Cycles per bus access
   localparam int NREGS       = 32 + `RF_CSR_REGS;

   logic       clk;
   logic       rst;
   logic       wb_cyc;
   logic       wb_stb;
   logic       wb_we;
   logic [1:0] wb_adr;
   wb_word_t   wb_dat_w;
   wb_word_t   wb_dat_r;
   logic       wb_ack;

   wb_word_t model [NREGS];   // Expected register contents
   integer   seed = 32'h243a;
   int       errors;
   int       checks;
   int       access_count;
   int       ack_count;

   serial_rf_top DUT (
      .i_clk    (clk),
      .i_rst    (rst),
      .i_wb_cyc (wb_cyc),
      .i_wb_stb (wb_stb),
      .i_wb_we  (wb_we),
      .i_wb_adr (wb_adr),
      .i_wb_dat (wb_dat_w),
      .o_wb_dat (wb_dat_r),
      .o_wb_ack (wb_ack)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Ack pulses counted away from the clock edge
   always @(negedge clk) begin
      if (wb_ack) begin
         ack_count++;
      end
   end

   initial begin
      repeat (WD_CYCLES) @(posedge clk);
      $display("ERROR: watchdog expired after %0d cycles, the run hung", WD_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   task automatic check_word(input string test, input string what,
                             input wb_word_t exp, input wb_word_t act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("[FAIL] %s (%s): expected %08h, actual %08h", test, what, exp, act);
      end
   endtask

   // One classic cycle, held until ack
   task automatic wb_access(input wb_addr_e adr, input logic we, input wb_word_t wdat,
                            output wb_word_t rdat);
      bit got;
      int n;
      got = 1'b0;
      @(posedge clk);
      #1;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdat;
      access_count++;
      for (n = 0; n < ACK_TIMEOUT && !got; n++) begin
         @(posedge clk);
         #1;
         got = wb_ack;
      end
      rdat   = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      if (!got) begin
         errors++;
         $display("ERROR: no ack within %0d cycles for access to address %0d",
                  ACK_TIMEOUT, adr);
      end
   endtask

   task automatic wb_write(input wb_addr_e adr, input wb_word_t dat);
      wb_word_t unused;
      wb_access(adr, 1'b1, dat, unused);
   endtask

   task automatic wb_read(input wb_addr_e adr, output wb_word_t dat);
      wb_access(adr, 1'b0, '0, dat);
   endtask

   function automatic wb_word_t wr_cmd_word(input rf_reg_t r0, input rf_reg_t r1,
                                            input logic e0, input logic e1);
      rf_wr_cmd_t c;
      c       = '0;
      c.op    = RF_OP_WRITE;
      c.wreg0 = r0;
      c.wreg1 = r1;
      c.wen0  = e0;
      c.wen1  = e1;
      return c;
   endfunction

   function automatic wb_word_t rd_cmd_word(input rf_reg_t r0, input rf_reg_t r1);
      rf_rd_cmd_t c;
      c       = '0;
      c.op    = RF_OP_READ;
      c.rreg0 = r0;
      c.rreg1 = r1;
      return c;
   endfunction

   function automatic rf_reg_t pick_reg();
      return rf_reg_t'($unsigned($random(seed)) % NREGS);
   endfunction

   task automatic write_pair(input rf_reg_t r0, input rf_reg_t r1, input logic e0,
                             input logic e1, input wb_word_t v0, input wb_word_t v1);
      wb_write(WB_DATA0, v0);
      wb_write(WB_DATA1, v1);
      wb_write(WB_CMD, wr_cmd_word(r0, r1, e0, e1));
      if (e0) begin
         model[r0] = v0;
      end
      if (e1) begin
         model[r1] = v1;
      end
   endtask

   task automatic read_pair(input string test, input rf_reg_t r0, input rf_reg_t r1);
      wb_word_t got0;
      wb_word_t got1;
      wb_write(WB_CMD, rd_cmd_word(r0, r1));
      wb_read(WB_DATA0, got0);
      wb_read(WB_DATA1, got1);
      check_word(test, $sformatf("x%0d on channel 0", r0), model[r0], got0);
      check_word(test, $sformatf("x%0d on channel 1", r1), model[r1], got1);
   endtask

   task automatic id_and_data_regs();
      wb_word_t v0;
      wb_word_t v1;
      wb_word_t got;
      int       acks_before;
      v0 = $random(seed);
      v1 = $random(seed);
      acks_before = ack_count;
      wb_read(WB_ID, got);
      check_word("id_regs", "ID value", WB_ID_VALUE, got);
      wb_write(WB_DATA0, v0);
      wb_write(WB_DATA1, v1);
      wb_read(WB_DATA0, got);
      check_word("id_regs", "DATA0 readback", v0, got);
      wb_read(WB_DATA1, got);
      check_word("id_regs", "DATA1 readback", v1, got);
      repeat (2) @(posedge clk);
      check_word("id_regs", "acks for 5 accesses", acks_before + 5, ack_count);
   endtask

   task automatic pair_write_readback();
      write_pair(1, 2, 1'b1, 1'b1, 32'hdead_beef, 32'h0123_4567);
      read_pair("pair_rw", 1, 2);
      read_pair("pair_rw", 2, 1);   // Swapped channels
   endtask

   task automatic single_enable();
      write_pair(3, 4, 1'b1, 1'b1, 32'h3333_0003, 32'h4444_0004);
      write_pair(3, 4, 1'b1, 1'b0, 32'ha5a5_5a5a, 32'hffff_ffff);
      read_pair("single_enable", 3, 4);
   endtask

   task automatic csr_slots();
      write_pair(32, 33, 1'b1, 1'b1, 32'hc5a0_0020, 32'hc5a0_0021);
      write_pair(34, 35, 1'b1, 1'b1, 32'hc5a0_0022, 32'hc5a0_0023);
      write_pair(0, 31, 1'b1, 1'b1, 32'h0000_0000, 32'h8000_001f);
      read_pair("csr_slots", 0, 32);
      read_pair("csr_slots", 33, 31);
      read_pair("csr_slots", 35, 34);
      // CSR write must leave general x0 and x31 alone
      write_pair(32, 0, 1'b1, 1'b0, 32'h1357_9bdf, 32'h2468_ace0);
      read_pair("csr_slots", 32, 0);
      read_pair("csr_slots", 31, 33);
   endtask

   task automatic same_reg_both_channels();
      write_pair(7, 8, 1'b1, 1'b1, 32'h7777_7777, 32'h8888_8881);
      read_pair("same_reg", 7, 7);
      read_pair("same_reg", 8, 8);
      read_pair("same_reg", 34, 34);
   endtask

   task automatic random_sweep();
      rf_reg_t    r0;
      rf_reg_t    r1;
      logic [1:0] en;
      rf_wr_cmd_t none_cmd;
      wb_word_t   got;
      // Fill every slot first so any read has a known value
      for (int r = 0; r < NREGS; r += 2) begin
         write_pair(rf_reg_t'(r), rf_reg_t'(r + 1), 1'b1, 1'b1, $random(seed), $random(seed));
      end
      for (int i = 0; i < 40; i++) begin
         r0 = pick_reg();
         r1 = pick_reg();
         while (r1 == r0) begin
            r1 = pick_reg();
         end
         en = $random(seed);
         write_pair(r0, r1, en[0], en[1], $random(seed), $random(seed));
         read_pair("random_sweep", pick_reg(), pick_reg());
      end
      // Op NONE with enables set and fresh operands loaded
      none_cmd       = '0;
      none_cmd.op    = RF_OP_NONE;
      none_cmd.wreg0 = pick_reg();
      none_cmd.wreg1 = pick_reg();
      none_cmd.wen0  = 1'b1;
      none_cmd.wen1  = 1'b1;
      wb_write(WB_DATA0, $random(seed));
      wb_write(WB_DATA1, $random(seed));
      wb_write(WB_CMD, none_cmd);
      wb_read(WB_CMD, got);
      check_word("op_none", "command readback", none_cmd, got);
      read_pair("op_none", none_cmd.wreg0, none_cmd.wreg1);
   endtask

   initial begin
      rst          = 1'b1;
      wb_cyc       = 1'b0;
      wb_stb       = 1'b0;
      wb_we        = 1'b0;
      wb_adr       = '0;
      wb_dat_w     = '0;
      errors       = 0;
      checks       = 0;
      access_count = 0;
      ack_count    = 0;
      repeat (5) @(posedge clk);
      #1 rst = 1'b0;

      id_and_data_regs();
      pair_write_readback();
      single_enable();
      csr_slots();
      same_reg_both_channels();
      random_sweep();

      repeat (4) @(posedge clk);
      check_word("bus", "acks over all accesses", access_count, ack_count);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* sources.f */
+incdir+hdl
hdl/rf_pkg.sv
hdl/wb_pkg.sv
hdl/rf_ram_if.sv
hdl/rf_ram.sv
hdl/rf_serdes.sv
hdl/rf_op_ctrl.sv
hdl/serial_rf_top.sv
tb/tb_serial_rf.sv

/* Bender.yml */
package:
  name: serial_rf

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rf_pkg.sv
      - hdl/wb_pkg.sv
      - hdl/rf_ram_if.sv
      - hdl/rf_ram.sv
      - hdl/rf_serdes.sv
      - hdl/rf_op_ctrl.sv
      - hdl/serial_rf_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - tb/tb_serial_rf.sv
